// File: hdl/arcade_host_pkg.sv
package arcade_host_pkg;

	// program store geometry
	localparam int rom_addr_w = 15;            // byte address
	localparam int rom_word_w = rom_addr_w - 1; // word address
	localparam int rom_depth  = 1 << rom_word_w;

	localparam int dl_addr_w = 25;

	// ps/2 set 2 scan codes
	localparam logic [7:0] key_up     = 8'h75;
	localparam logic [7:0] key_down   = 8'h72;
	localparam logic [7:0] key_left   = 8'h6b;
	localparam logic [7:0] key_right  = 8'h74;
	localparam logic [7:0] key_coin   = 8'h76; // esc
	localparam logic [7:0] key_start1 = 8'h05; // f1
	localparam logic [7:0] key_start2 = 8'h06; // f2
	localparam logic [7:0] key_fire1  = 8'h29; // space
	localparam logic [7:0] key_fire2  = 8'h11; // left alt

	localparam int status_reset = 0; // menu reset bit

	typedef struct packed {
		logic                 active;
		logic                 wr;
		logic [dl_addr_w-1:0] addr;
		logic [7:0]           data;
	} dl_bus_t;

	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic coin;
		logic start1;
		logic start2;
	} controls_t;

	// written as one halfword, read back a byte at a time
	typedef union packed {
		logic [15:0] half;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
	} rom_word_u;

	typedef struct packed {
		logic                  en;
		logic [1:0]            lanes; // bit 1 = high byte
		logic [rom_word_w-1:0] addr;
		rom_word_u             data;
	} store_wr_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       blank_n;
		logic       hs;
		logic       vs;
		logic       csync;
	} core_video_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_out_t;

endpackage

// File: hdl/input_mapper.sv
module input_mapper
	import arcade_host_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst_n,
	input  key_event_t key,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	output controls_t  controls
);

	controls_t  held; // keyboard levels
	logic [5:0] joy;  // both players merged

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			held <= '0;
		end else if (key.strobe) begin
			case (key.code)
				key_up: begin
					held.up <= key.pressed;
				end
				key_down: begin
					held.down <= key.pressed;
				end
				key_left: begin
					held.left <= key.pressed;
				end
				key_right: begin
					held.right <= key.pressed;
				end
				key_coin: begin
					held.coin <= key.pressed;
				end
				key_start1: begin
					held.start1 <= key.pressed;
				end
				key_start2: begin
					held.start2 <= key.pressed;
				end
				key_fire1: begin
					held.fire1 <= key.pressed;
				end
				key_fire2: begin
					held.fire2 <= key.pressed;
				end
				default: begin
					held <= held; // unknown code
				end
			endcase
		end
	end

	// bits 6 and 7 are not game controls
	assign joy = joystick_0[5:0] | joystick_1[5:0];

	always_comb begin
		controls        = held;
		controls.right  = held.right | joy[0];
		controls.left   = held.left  | joy[1];
		controls.down   = held.down  | joy[2];
		controls.up     = held.up    | joy[3];
		controls.fire1  = held.fire1 | joy[4];
		controls.fire2  = held.fire2 | joy[5];
		// coin and starts stay keyboard only
	end

endmodule

// File: hdl/rom_loader.sv
module rom_loader
	import arcade_host_pkg::*;
(
	input  logic        sys_clk,
	input  logic        rst_n,
	input  dl_bus_t     dl,
	input  logic [31:0] status,
	input  logic [1:0]  buttons,
	output store_wr_t   store_wr,
	output logic        core_reset
);

	logic wr_d;       // previous dl.wr
	logic active_d;   // previous dl.active
	logic rom_loaded;
	logic wr_en;
	logic wr_edge;

	logic [1:0]            wr_lanes;
	logic [rom_word_w-1:0] wr_addr;
	rom_word_u             wr_data;

	assign wr_edge = dl.active && dl.wr && !wr_d;

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_d       <= 1'b0;
			active_d   <= 1'b0;
			wr_en      <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
		end else begin
			wr_d     <= dl.wr;
			active_d <= dl.active;
			wr_en    <= wr_edge;

			// end of download
			if (active_d && !dl.active) begin
				rom_loaded <= 1'b1;
			end

			core_reset <= !rom_loaded | status[status_reset] | buttons[1];
		end
	end

	// write payload
	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_lanes <= '0;
			wr_addr  <= '0;
			wr_data  <= '0;
		end else if (wr_edge) begin
			wr_lanes     <= {dl.addr[0], ~dl.addr[0]}; // odd byte -> high lane
			wr_addr      <= dl.addr[rom_addr_w-1:1];
			wr_data.half <= {dl.data, dl.data};
		end
	end

	assign store_wr.en    = wr_en;
	assign store_wr.lanes = wr_lanes;
	assign store_wr.addr  = wr_addr;
	assign store_wr.data  = wr_data;

endmodule

// File: hdl/rom_store.sv
module rom_store
	import arcade_host_pkg::*;
(
	input  logic                  sys_clk,
	input  store_wr_t             store_wr,
	input  logic [rom_addr_w-1:0] rom_addr,
	output logic [7:0]            rom_byte
);

	rom_word_u mem [rom_depth];

	rom_word_u rd_word;
	logic      hi_sel; // registered byte select

	// write port, per lane
	always_ff @(posedge sys_clk) begin
		if (store_wr.en) begin
			if (store_wr.lanes[1]) begin
				mem[store_wr.addr].half[15:8] <= store_wr.data.half[15:8];
			end
			if (store_wr.lanes[0]) begin
				mem[store_wr.addr].half[7:0] <= store_wr.data.half[7:0];
			end
		end
	end

	// cpu read port
	always_ff @(posedge sys_clk) begin
		rd_word <= mem[rom_addr[rom_addr_w-1:1]];
		hi_sel  <= rom_addr[0];
	end

	assign rom_byte = hi_sel ? rd_word.bytes.hi : rd_word.bytes.lo;

endmodule

// File: hdl/video_out.sv
module video_out
	import arcade_host_pkg::*;
(
	input  logic        sys_clk,
	input  logic        rst_n,
	input  core_video_t core_video,
	input  logic        tv15k_mode,
	output vga_out_t    vga
);

	logic [2:0] blue_wide;

	// 2 bit blue up to 3 bits, msb repeated
	assign blue_wide = {core_video.b, core_video.b[1]};

	always_ff @(posedge sys_clk or negedge rst_n) begin
		if (!rst_n) begin
			vga <= '0;
		end else begin
			if (core_video.blank_n) begin
				vga.r <= {core_video.r, core_video.r};
				vga.g <= {core_video.g, core_video.g};
				vga.b <= {blue_wide, blue_wide};
			end else begin
				vga.r <= '0;
				vga.g <= '0;
				vga.b <= '0;
			end

			// tv mode carries composite sync on hs
			vga.hs <= tv15k_mode ? core_video.csync : core_video.hs;
			vga.vs <= tv15k_mode | core_video.vs;
		end
	end

endmodule

// File: hdl/arcade_host_top.sv
module arcade_host_top
	import arcade_host_pkg::*;
(
	input  logic                  sys_clk,
	input  logic                  rst_n,

	// download channel and menu
	input  dl_bus_t               dl,
	input  logic [31:0]           status,
	input  logic [1:0]            buttons,

	// player inputs
	input  key_event_t            key,
	input  logic [7:0]            joystick_0,
	input  logic [7:0]            joystick_1,

	// core side
	input  logic [rom_addr_w-1:0] rom_addr,
	input  core_video_t           core_video,
	input  logic                  tv15k_mode,

	output controls_t             controls,
	output logic                  core_reset,
	output logic [7:0]            rom_byte,
	output vga_out_t              vga
);

	store_wr_t store_wr; // loader -> store

	input_mapper u_input_mapper (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.key        (key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.controls   (controls)
	);

	rom_loader u_rom_loader (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.dl         (dl),
		.status     (status),
		.buttons    (buttons),
		.store_wr   (store_wr),
		.core_reset (core_reset)
	);

	rom_store u_rom_store (
		.sys_clk  (sys_clk),
		.store_wr (store_wr),
		.rom_addr (rom_addr),
		.rom_byte (rom_byte)
	);

	video_out u_video_out (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.core_video (core_video),
		.tv15k_mode (tv15k_mode),
		.vga        (vga)
	);

endmodule

// File: sim/tb_clock.sv
module tb_clock #(
	parameter int reset_cycles = 10
) (
	output logic sys_clk,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam realtime half_period = 50ns; // 100 ns clock

	initial begin
		sys_clk = 1'b0;
		forever #(half_period) sys_clk = ~sys_clk;
	end

	initial begin
		rst_n <= 1'b0;
		repeat (reset_cycles) @(posedge sys_clk);
		rst_n <= 1'b1; // released on a rising edge
	end

endmodule

// File: sim/tb_arcade_host.sv
module tb_arcade_host
	import arcade_host_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int reset_cycles = 10;
	localparam int dl_len       = 64;
	localparam int key_len      = 22; // 11 codes pressed then released
	localparam int joy_len      = 16;
	localparam int video_len    = 200;
	localparam int max_cycles   = reset_cycles + dl_len * 6 + key_len * 2 + joy_len
		+ video_len + 100;

	logic                  sys_clk;
	logic                  rst_n;
	dl_bus_t               dl;
	logic [31:0]           status;
	logic [1:0]            buttons;
	key_event_t            key;
	logic [7:0]            joystick_0;
	logic [7:0]            joystick_1;
	logic [rom_addr_w-1:0] rom_addr;
	core_video_t           core_video;
	logic                  tv15k_mode;
	controls_t             controls;
	logic                  core_reset;
	logic [7:0]            rom_byte;
	vga_out_t              vga;

	logic [dl_addr_w-1:0] dl_addr_tab [dl_len];
	logic [7:0]           dl_data_tab [dl_len];
	core_video_t          vid_in      [video_len];
	logic                 vid_tv      [video_len];
	vga_out_t             vid_exp     [video_len];

	// nine mapped codes then two unknown ones
	logic [7:0] key_code [11] = '{8'h75, 8'h72, 8'h6b, 8'h74, 8'h76, 8'h05, 8'h06, 8'h29,
		8'h11, 8'h1c, 8'hf0};
	int key_bit [11] = '{8, 7, 6, 5, 2, 1, 0, 4, 3, -1, -1}; // controls bit or -1 for none
	int joy_ctrl [6] = '{5, 6, 7, 8, 4, 3}; // right left down up fire1 fire2

	int cycle_count = 0;

	tb_clock #(.reset_cycles(reset_cycles)) u_clock (
		.sys_clk (sys_clk),
		.rst_n   (rst_n)
	);

	arcade_host_top DUT (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.dl         (dl),
		.status     (status),
		.buttons    (buttons),
		.key        (key),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rom_addr   (rom_addr),
		.core_video (core_video),
		.tv15k_mode (tv15k_mode),
		.controls   (controls),
		.core_reset (core_reset),
		.rom_byte   (rom_byte),
		.vga        (vga)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic vga_out_t expected_vga(input core_video_t v, input logic tv);
		vga_out_t   e;
		logic [2:0] b3;
		e  = '0;
		b3 = {v.b, v.b[1]}; // top bit appended
		if (v.blank_n) begin
			e.r = 6'(v.r) * 6'd9; // x9 repeats a 3 bit value
			e.g = 6'(v.g) * 6'd9;
			e.b = 6'(b3) * 6'd9;
		end
		e.hs = tv ? v.csync : v.hs;
		e.vs = tv ? 1'b1 : v.vs;
		return e;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	// raise a reset request for two cycles and watch core_reset follow
	task automatic request_reset(input logic [31:0] st, input logic [1:0] bt,
		input logic exp_high);
		@(posedge sys_clk);
		status  <= st;
		buttons <= bt;
		@(negedge sys_clk);
		compare_value("core_reset", 32'(core_reset), 32'd0);
		@(posedge sys_clk);
		@(negedge sys_clk);
		compare_value("core_reset", 32'(core_reset), 32'(exp_high));
		@(posedge sys_clk);
		status  <= '0;
		buttons <= '0;
		@(negedge sys_clk);
		compare_value("core_reset", 32'(core_reset), 32'(exp_high));
		@(posedge sys_clk);
		@(negedge sys_clk);
		compare_value("core_reset", 32'(core_reset), 32'd0);
	endtask

	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	initial begin
		int          i;
		int          k;
		int          b;
		int          phase;
		logic [31:0] rnd;
		logic [8:0]  held_model;
		logic [8:0]  exp9;

		dl         <= '0;
		status     <= '0;
		buttons    <= '0;
		key        <= '0;
		joystick_0 <= '0;
		joystick_1 <= '0;
		rom_addr   <= '0;
		core_video <= '0;
		tv15k_mode <= 1'b0;

		// low addresses fill whole words and the rest spread over the store
		rnd = 32'hc728_6402;
		for (i = 0; i < dl_len; i++) begin
			if (i < 32) begin
				dl_addr_tab[i] = 25'(i);
			end else begin
				dl_addr_tab[i] = 25'(32767 - (i - 32) * 37);
			end
			rnd            = xorshift32(rnd);
			dl_data_tab[i] = rnd[7:0];
		end
		for (i = 0; i < video_len; i++) begin
			rnd        = xorshift32(rnd);
			vid_in[i]  = core_video_t'(rnd[23:12]);
			vid_tv[i]  = rnd[5];
			vid_exp[i] = expected_vga(vid_in[i], vid_tv[i]);
		end

		@(posedge rst_n);
		@(negedge sys_clk);
		compare_value("core_reset", 32'(core_reset), 32'd1);
		compare_value("controls", 32'(controls), 32'd0);
		compare_value("vga", 32'(vga), 32'd0);

		// download with one write strobe every four cycles
		@(posedge sys_clk);
		dl.active <= 1'b1;
		for (i = 0; i < dl_len; i++) begin
			for (phase = 0; phase < 4; phase++) begin
				@(posedge sys_clk);
				if (phase == 0) begin
					dl.addr <= dl_addr_tab[i];
					dl.data <= dl_data_tab[i];
				end
				dl.wr <= (phase == 0);
				@(negedge sys_clk);
				compare_value("core_reset", 32'(core_reset), 32'd1);
			end
		end
		@(posedge sys_clk);
		dl.active <= 1'b0;
		@(negedge sys_clk);
		compare_value("core_reset", 32'(core_reset), 32'd1);
		@(posedge sys_clk);
		@(negedge sys_clk);
		compare_value("core_reset", 32'(core_reset), 32'd1);
		@(posedge sys_clk);
		@(negedge sys_clk);
		compare_value("core_reset", 32'(core_reset), 32'd0); // two cycles after fall

		request_reset(32'h1, 2'b00, 1'b1);
		request_reset(32'h0, 2'b10, 1'b1);
		request_reset(32'h0, 2'b01, 1'b0);
		request_reset(32'h2, 2'b00, 1'b0);

		// readback with the address one cycle ahead of its byte
		for (i = 0; i <= dl_len; i++) begin
			@(posedge sys_clk);
			if (i < dl_len) begin
				rom_addr <= dl_addr_tab[i][rom_addr_w-1:0];
			end
			@(negedge sys_clk);
			if (i > 0) begin
				compare_value("rom_byte", 32'(rom_byte), 32'(dl_data_tab[i-1]));
			end
		end

		held_model = '0;
		for (i = 0; i < key_len; i++) begin
			k = i % 11;
			@(posedge sys_clk);
			key.strobe  <= 1'b1;
			key.pressed <= (i < 11);
			key.code    <= key_code[k];
			@(negedge sys_clk);
			compare_value("controls", 32'(controls), 32'(held_model));
			@(posedge sys_clk);
			key.strobe <= 1'b0;
			if (key_bit[k] >= 0) begin
				held_model[key_bit[k]] = (i < 11);
			end
			@(negedge sys_clk);
			compare_value("controls", 32'(controls), 32'(held_model));
		end

		for (i = 0; i < joy_len; i++) begin
			b = i % 8;
			@(posedge sys_clk);
			if (i < 8) begin
				joystick_0 <= 8'(1 << b);
				joystick_1 <= '0;
			end else begin
				joystick_0 <= '0;
				joystick_1 <= 8'(1 << b);
			end
			exp9 = (b < 6) ? 9'(1 << joy_ctrl[b]) : 9'h0; // bits 6 and 7 unused
			@(negedge sys_clk);
			compare_value("controls", 32'(controls), 32'(exp9));
		end
		@(posedge sys_clk);
		joystick_0 <= '0;
		joystick_1 <= '0;

		for (i = 0; i <= video_len; i++) begin
			@(posedge sys_clk);
			if (i < video_len) begin
				core_video <= vid_in[i];
				tv15k_mode <= vid_tv[i];
			end
			@(negedge sys_clk);
			if (i > 0) begin
				compare_value("vga", 32'(vga), 32'(vid_exp[i-1]));
			end
		end

		@(posedge sys_clk);
		$display("All tests passed");
		$finish;
	end

endmodule

// File: all.f
hdl/arcade_host_pkg.sv
hdl/input_mapper.sv
hdl/rom_loader.sv
hdl/rom_store.sv
hdl/video_out.sv
hdl/arcade_host_top.sv
sim/tb_clock.sv
sim/tb_arcade_host.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter the project root"
	exit 1
fi

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps -f all.f \
	--top-module tb_arcade_host -o sim_arcade_host
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_arcade_host > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "All tests passed" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
